/* src.f */
mini_mips_pkg.sv
if_stage.sv
pipe_reg.sv
id_stage.sv
regfile.sv
exe_stage.sv
mini_mips32.sv
tb_mini_mips32.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mini_mips32
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_mini_mips32.sv */
`timescale 1ns/10ps

module tb_mini_mips32 import mini_mips_pkg::*; ();

    localparam word_t RESET_PC  = 32'hBFC0_0000;
    localparam int    PROG_MAX  = 64;
    localparam int    CLK_HALF  = 4;
    localparam int    DRIVE_DLY = 1;

    localparam logic [5:0] R_FNS   [7] = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h2a, 6'h00};
    localparam logic [5:0] I_OPS   [3] = '{6'h09, 6'h0d, 6'h0f};
    localparam logic [5:0] BAD_OPS [6] = '{6'h02, 6'h04, 6'h08, 6'h0c, 6'h23, 6'h2b};
    localparam logic [5:0] BAD_FNS [6] = '{6'h02, 6'h08, 6'h10, 6'h20, 6'h22, 6'h2b};

    typedef struct packed {
        word_t     pc;
        logic      wen;
        reg_addr_t wnum;
        word_t     wdata;
    } retire_t;

    logic       clk;
    logic       arst_n;
    word_t      inst;
    word_t      iaddr;
    logic       ice;
    word_t      wb_pc;
    logic [3:0] wb_wen;
    reg_addr_t  wb_wnum;
    word_t      wb_wdata;

    word_t   rom [PROG_MAX];
    word_t   model_regs [32];
    retire_t expected [$];
    int      fetches [$];                 // Cycle of each fetch
    integer  seed = 32'h1c4ac068;
    int      err_cnt = 0;
    int      check_cnt = 0;
    int      test_cnt = 0;
    int      bad_tests = 0;

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    mini_mips32 #(.RESET_PC(RESET_PC)) dut (
        .cpu_clk_50M         (clk),
        .arst_n_i            (arst_n),
        .inst_i              (inst),
        .iaddr_o             (iaddr),
        .ice_o               (ice),
        .debug_wb_pc_o       (wb_pc),
        .debug_wb_rf_wen_o   (wb_wen),
        .debug_wb_rf_wnum_o  (wb_wnum),
        .debug_wb_rf_wdata_o (wb_wdata)
    );

    function automatic word_t rtype_word(input logic [5:0] fn, input reg_addr_t rs,
                                         input reg_addr_t rt, input reg_addr_t rd,
                                         input logic [4:0] sa);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t itype_word(input logic [5:0] op, input reg_addr_t rs,
                                         input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic int rand_below(input int n);
        return int'({$random(seed)} % n);
    endfunction

    function automatic reg_addr_t pool_reg();
        return reg_addr_t'(rand_below(4) + 1);    // Small pool r1..r4
    endfunction

    task automatic compare_word(input string sig, input word_t got, input word_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %s: got %h expected %h", sig, got, exp);
        end
    endtask

    // In-order ISA model of one instruction
    task automatic model_exec(input word_t instr, input word_t pc, output retire_t r);
        word_t      a;
        word_t      b;
        word_t      val;
        reg_addr_t  dest;
        logic       known;
        a     = model_regs[instr[25:21]];
        b     = model_regs[instr[20:16]];
        val   = '0;
        dest  = instr[20:16];
        known = 1'b1;
        if (instr[31:26] == 6'h00) begin
            dest = instr[15:11];
            case (instr[5:0])
                6'h21:   val = a + b;
                6'h23:   val = a - b;
                6'h24:   val = a & b;
                6'h25:   val = a | b;
                6'h26:   val = a ^ b;
                6'h2a:   val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                6'h00:   val = b << instr[10:6];
                default: known = 1'b0;
            endcase
        end else if (instr[31:26] == 6'h09) begin
            val = a + {{16{instr[15]}}, instr[15:0]};
        end else if (instr[31:26] == 6'h0d) begin
            val = a | {16'h0000, instr[15:0]};
        end else if (instr[31:26] == 6'h0f) begin
            val = {instr[15:0], 16'h0000};
        end else begin
            known = 1'b0;
        end
        r.pc    = pc;
        r.wen   = known && (dest != 5'd0);
        r.wnum  = dest;
        r.wdata = val;
        if (r.wen) begin
            model_regs[dest] = val;
        end
    endtask

    // Mode 0 R-type, 1 I-type, 2 register zero and unknown encodings
    task automatic fill_random(input int mode, input int n);
        word_t rnd;
        for (int i = 0; i < n; i++) begin
            rnd = $random(seed);
            if (i < 8) begin
                rom[i] = (i < 4) ? itype_word(6'h0f, 5'd0, reg_addr_t'(i + 1), rnd[15:0])
                                 : itype_word(6'h0d, reg_addr_t'(i - 3), reg_addr_t'(i - 3),
                                              rnd[31:16]);
            end else if (mode == 0) begin
                rom[i] = rtype_word(R_FNS[rand_below(7)], pool_reg(), pool_reg(), pool_reg(),
                                    5'd0);
                if (rom[i][5:0] == 6'h00) begin
                    rom[i][10:6] = rnd[4:0];
                end
            end else if (mode == 1) begin
                rom[i] = itype_word(I_OPS[rand_below(3)], pool_reg(), pool_reg(), rnd[15:0]);
            end else begin
                case (rand_below(5))
                    0: rom[i] = rtype_word(R_FNS[rand_below(7)], pool_reg(), pool_reg(),
                                           5'd0, 5'd0);
                    1: rom[i] = itype_word(I_OPS[rand_below(3)], pool_reg(), 5'd0, rnd[15:0]);
                    2: rom[i] = itype_word(BAD_OPS[rand_below(6)], pool_reg(), pool_reg(),
                                           rnd[15:0]);
                    3: rom[i] = rtype_word(BAD_FNS[rand_below(6)], pool_reg(), pool_reg(),
                                           pool_reg(), 5'd0);
                    default: rom[i] = rtype_word(6'h21, 5'd0, pool_reg(), pool_reg(), 5'd0);
                endcase
            end
        end
    endtask

    task automatic apply_reset();
        inst   = '0;
        arst_n = 1'b0;
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #DRIVE_DLY;
            compare_word("ice_o", {31'b0, ice}, 32'h0);
            compare_word("debug_wb_rf_wen_o", {28'b0, wb_wen}, 32'h0);
        end
        arst_n = 1'b1;
    endtask

    task automatic run_program(input string name, input int n);
        retire_t r;
        word_t   prev_addr;
        logic    prev_ice;
        int      idx;
        int      retired;
        int      fetched;
        int      cyc;
        int      errs_before;
        errs_before = err_cnt;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        expected.delete();
        fetches.delete();
        for (int i = 0; i < n; i++) begin
            model_exec(rom[i], RESET_PC + 32'(4 * i), r);
            expected.push_back(r);
        end
        apply_reset();
        prev_ice  = 1'b0;
        prev_addr = '0;
        retired   = 0;
        fetched   = 0;
        cyc       = 0;
        while (retired < n && cyc < n + 16) begin
            @(posedge clk);
            #DRIVE_DLY;
            idx  = int'((prev_addr - RESET_PC) >> 2);
            inst = (prev_ice && idx < n) ? rom[idx] : 32'h0;   // NOP past the end
            if (ice) begin
                compare_word("iaddr_o", iaddr, RESET_PC + 32'(4 * fetched));
                fetches.push_back(cyc);
                fetched++;
            end
            if (fetches.size() > 0 && fetches[0] + 3 == cyc) begin
                fetches.delete(0);
                r = expected[retired];
                compare_word("debug_wb_pc_o", wb_pc, r.pc);
                compare_word("debug_wb_rf_wen_o", {28'b0, wb_wen}, {28'b0, {4{r.wen}}});
                if (r.wen) begin
                    compare_word("debug_wb_rf_wnum_o", {27'b0, wb_wnum}, {27'b0, r.wnum});
                    compare_word("debug_wb_rf_wdata_o", wb_wdata, r.wdata);
                end
                retired++;
            end else begin
                compare_word("debug_wb_rf_wen_o", {28'b0, wb_wen}, 32'h0);
            end
            prev_ice  = ice;
            prev_addr = iaddr;
            cyc++;
        end
        if (retired < n) begin
            err_cnt++;
            $display("Timeout in %s, only %0d of %0d instructions retired", name, retired, n);
        end
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("PASS %s: %0d instructions retired", name, retired);
        end else begin
            bad_tests++;
            $display("FAIL %s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    initial begin
        arst_n = 1'b0;
        inst   = '0;
        for (int i = 0; i < 4; i++) begin
            rom[i] = '0;
        end
        run_program("reset_and_first_fetch", 4);
        for (int i = 0; i < 24; i++) begin
            rom[i] = itype_word(6'h09, 5'd1, 5'd1, 16'h0001);   // Counter chain in r1
        end
        run_program("fetch_timing", 24);
        for (int t = 0; t < 3; t++) begin
            fill_random(0, PROG_MAX);
            run_program("rtype_random", PROG_MAX);
        end
        for (int t = 0; t < 3; t++) begin
            fill_random(1, PROG_MAX);
            run_program("itype_random", PROG_MAX);
        end
        for (int t = 0; t < 2; t++) begin
            fill_random(2, PROG_MAX);
            run_program("zero_and_unknown", PROG_MAX);
        end
        $display("Summary: %0d tests run, %0d with errors, %0d checks, %0d errors",
                 test_cnt, bad_tests, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* mini_mips32.sv */
`timescale 1ns/10ps

module mini_mips32 import mini_mips_pkg::*; #(
    parameter word_t RESET_PC = 32'hBFC0_0000
) (
    input  logic       cpu_clk_50M,
    input  logic       arst_n_i,
    input  word_t      inst_i,
    output word_t      iaddr_o,
    output logic       ice_o,
    output word_t      debug_wb_pc_o,
    output logic [3:0] debug_wb_rf_wen_o,
    output reg_addr_t  debug_wb_rf_wnum_o,
    output word_t      debug_wb_rf_wdata_o
);

    ifid_t     if_ifid;
    ifid_t     id_ifid;
    idexe_t    id_idexe;
    idexe_t    exe_idexe;
    exewb_t    exe_exewb;
    exewb_t    wb_exewb;
    wb_bus_t   exe_fwd;
    reg_addr_t ra1;
    reg_addr_t ra2;
    word_t     rd1;
    word_t     rd2;

    if_stage #(.RESET_PC(RESET_PC)) if_stage0 (
        .cpu_clk_50M (cpu_clk_50M),
        .arst_n_i    (arst_n_i),
        .iaddr_o     (iaddr_o),
        .ice_o       (ice_o),
        .ifid_o      (if_ifid)
    );

    pipe_reg #(.payload_t(ifid_t)) ifid_reg0 (
        .cpu_clk_50M (cpu_clk_50M),
        .arst_n_i    (arst_n_i),
        .d_i         (if_ifid),
        .q_o         (id_ifid)
    );

    id_stage id_stage0 (
        .ifid_i    (id_ifid),
        .inst_i    (inst_i),          // Arrives with the PC it was fetched for
        .ra1_o     (ra1),
        .ra2_o     (ra2),
        .rd1_i     (rd1),
        .rd2_i     (rd2),
        .exe_fwd_i (exe_fwd),
        .idexe_o   (id_idexe)
    );

    regfile regfile0 (
        .cpu_clk_50M (cpu_clk_50M),
        .arst_n_i    (arst_n_i),
        .wb_i        (wb_exewb.wb),
        .ra1_i       (ra1),
        .ra2_i       (ra2),
        .rd1_o       (rd1),
        .rd2_o       (rd2)
    );

    pipe_reg #(.payload_t(idexe_t)) idexe_reg0 (
        .cpu_clk_50M (cpu_clk_50M),
        .arst_n_i    (arst_n_i),
        .d_i         (id_idexe),
        .q_o         (exe_idexe)
    );

    exe_stage exe_stage0 (
        .idexe_i   (exe_idexe),
        .exewb_o   (exe_exewb),
        .exe_fwd_o (exe_fwd)
    );

    pipe_reg #(.payload_t(exewb_t)) exewb_reg0 (
        .cpu_clk_50M (cpu_clk_50M),
        .arst_n_i    (arst_n_i),
        .d_i         (exe_exewb),
        .q_o         (wb_exewb)
    );

    assign debug_wb_pc_o       = wb_exewb.pc;
    assign debug_wb_rf_wen_o   = {4{wb_exewb.wb.wreg}};
    assign debug_wb_rf_wnum_o  = wb_exewb.wb.wa;
    assign debug_wb_rf_wdata_o = wb_exewb.wb.wd;

endmodule

/* exe_stage.sv */
`timescale 1ns/10ps

module exe_stage import mini_mips_pkg::*; (
    input  idexe_t  idexe_i,
    output exewb_t  exewb_o,
    output wb_bus_t exe_fwd_o
);

    word_t   result;
    wb_bus_t wb;

    always_comb begin
        case (idexe_i.aluop)
            ALU_ADD: result = idexe_i.src1 + idexe_i.src2;
            ALU_SUB: result = idexe_i.src1 - idexe_i.src2;
            ALU_AND: result = idexe_i.src1 & idexe_i.src2;
            ALU_OR:  result = idexe_i.src1 | idexe_i.src2;
            ALU_XOR: result = idexe_i.src1 ^ idexe_i.src2;
            ALU_SLT: result = {31'b0, $signed(idexe_i.src1) < $signed(idexe_i.src2)};
            ALU_SLL: result = idexe_i.src2 << idexe_i.src1[4:0];
            ALU_LUI: result = {idexe_i.src2[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    always_comb begin
        wb.wreg = idexe_i.wreg;
        wb.wa   = idexe_i.wa;
        wb.wd   = result;
    end

    assign exewb_o.wb = wb;
    assign exewb_o.pc = idexe_i.pc;
    assign exe_fwd_o  = wb;               // Same write, one cycle ahead of write-back

endmodule

/* regfile.sv */
`timescale 1ns/10ps

module regfile import mini_mips_pkg::*; (
    input  logic      cpu_clk_50M,
    input  logic      arst_n_i,
    input  wb_bus_t   wb_i,
    input  reg_addr_t ra1_i,
    input  reg_addr_t ra2_i,
    output word_t     rd1_o,
    output word_t     rd2_o
);

    word_t regs [REG_NUM];

    always_ff @(posedge cpu_clk_50M or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.wreg && wb_i.wa != '0) begin
            regs[wb_i.wa] <= wb_i.wd;
        end
    end

    // Read with write-through bypass
    function automatic word_t read_port(input reg_addr_t ra);
        word_t data;
        if (ra == '0) begin
            data = '0;
        end else if (wb_i.wreg && wb_i.wa == ra) begin
            data = wb_i.wd;
        end else begin
            data = regs[ra];
        end
        return data;
    endfunction

    always_comb begin
        rd1_o = read_port(ra1_i);
        rd2_o = read_port(ra2_i);
    end

endmodule

/* id_stage.sv */
`timescale 1ns/10ps

module id_stage import mini_mips_pkg::*; (
    input  ifid_t     ifid_i,
    input  word_t     inst_i,
    output reg_addr_t ra1_o,
    output reg_addr_t ra2_o,
    input  word_t     rd1_i,
    input  word_t     rd2_i,
    input  wb_bus_t   exe_fwd_i,
    output idexe_t    idexe_o
);

    logic [5:0]  op;
    logic [5:0]  fn;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [4:0]  sa;
    logic [15:0] imm;

    aluop_e      aluop;
    logic        known;
    logic        rtype;
    logic        use_imm;
    logic        is_sll;
    word_t       imm_ext;
    word_t       op1;
    word_t       op2;
    reg_addr_t   wa;

    assign op  = inst_i[31:26];
    assign rs  = inst_i[25:21];
    assign rt  = inst_i[20:16];
    assign rd  = inst_i[15:11];
    assign sa  = inst_i[10:6];
    assign fn  = inst_i[5:0];
    assign imm = inst_i[15:0];

    assign ra1_o = rs;
    assign ra2_o = rt;

    always_comb begin
        aluop   = ALU_ADD;
        known   = 1'b0;
        rtype   = 1'b0;
        use_imm = 1'b0;
        is_sll  = 1'b0;
        imm_ext = '0;
        case (op)
            OP_SPECIAL: begin
                rtype = 1'b1;
                known = 1'b1;
                case (fn)
                    FN_ADDU: aluop = ALU_ADD;
                    FN_SUBU: aluop = ALU_SUB;
                    FN_AND:  aluop = ALU_AND;
                    FN_OR:   aluop = ALU_OR;
                    FN_XOR:  aluop = ALU_XOR;
                    FN_SLT:  aluop = ALU_SLT;
                    FN_SLL: begin
                        aluop  = ALU_SLL;
                        is_sll = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                aluop   = ALU_ADD;
                known   = 1'b1;
                use_imm = 1'b1;
                imm_ext = {{16{imm[15]}}, imm};   // Sign extend
            end
            OP_ORI: begin
                aluop   = ALU_OR;
                known   = 1'b1;
                use_imm = 1'b1;
                imm_ext = {16'h0000, imm};
            end
            OP_LUI: begin
                aluop   = ALU_LUI;
                known   = 1'b1;
                use_imm = 1'b1;
                imm_ext = {16'h0000, imm};       // Moved to the upper half in execute
            end
            default: ;
        endcase
    end

    // Execute result wins over the regfile port
    assign op1 = (exe_fwd_i.wreg && exe_fwd_i.wa == rs && rs != '0) ? exe_fwd_i.wd : rd1_i;
    assign op2 = (exe_fwd_i.wreg && exe_fwd_i.wa == rt && rt != '0) ? exe_fwd_i.wd : rd2_i;

    assign wa = rtype ? rd : rt;

    always_comb begin
        idexe_o.aluop = aluop;
        idexe_o.src1  = is_sll ? {27'b0, sa} : op1;
        idexe_o.src2  = use_imm ? imm_ext : op2;
        idexe_o.wa    = wa;
        idexe_o.wreg  = known && (wa != '0);
        idexe_o.pc    = ifid_i.pc;
    end

    always_comb begin
        assert (!(idexe_o.wreg && idexe_o.wa == '0))
            else $error("id_stage: write enabled for register zero");
    end

endmodule

/* pipe_reg.sv */
`timescale 1ns/10ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     cpu_clk_50M,
    input  logic     arst_n_i,
    input  payload_t d_i,
    output payload_t q_o
);

    always_ff @(posedge cpu_clk_50M or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o <= '0;                    // All-zero struct is a bubble
        end else begin
            q_o <= d_i;
        end
    end

    a_bubble_after_reset : assert property (@(posedge cpu_clk_50M)
        !arst_n_i |=> q_o == '0)
        else $error("pipe_reg: stage not cleared after reset");

endmodule

/* if_stage.sv */
`timescale 1ns/10ps

module if_stage import mini_mips_pkg::*; #(
    parameter word_t RESET_PC = 32'hBFC0_0000
) (
    input  logic  cpu_clk_50M,
    input  logic  arst_n_i,
    output word_t iaddr_o,
    output logic  ice_o,
    output ifid_t ifid_o
);

    word_t pc;
    logic  ice;

    always_ff @(posedge cpu_clk_50M or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ice <= 1'b0;
            pc  <= RESET_PC;
        end else begin
            ice <= 1'b1;
            if (ice) begin
                pc <= pc + 32'd4;         // Hold RESET_PC until fetch starts
            end
        end
    end

    assign iaddr_o   = pc;
    assign ice_o     = ice;
    assign ifid_o.pc = ice ? pc : '0;     // Bubble before the first fetch

endmodule

/* mini_mips_pkg.sv */
package mini_mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam int REG_NUM = 32;

    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    localparam logic [5:0] FN_ADDU    = 6'b100001;
    localparam logic [5:0] FN_SUBU    = 6'b100011;
    localparam logic [5:0] FN_AND     = 6'b100100;
    localparam logic [5:0] FN_OR      = 6'b100101;
    localparam logic [5:0] FN_XOR     = 6'b100110;
    localparam logic [5:0] FN_SLT     = 6'b101010;
    localparam logic [5:0] FN_SLL     = 6'b000000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI
    } aluop_e;

    // Register write, also used as the execute forward
    typedef struct packed {
        logic      wreg;
        reg_addr_t wa;
        word_t     wd;
    } wb_bus_t;

    typedef struct packed {
        word_t pc;
    } ifid_t;

    typedef struct packed {
        aluop_e    aluop;
        word_t     src1;
        word_t     src2;
        reg_addr_t wa;
        logic      wreg;
        word_t     pc;
    } idexe_t;

    typedef struct packed {
        wb_bus_t wb;
        word_t   pc;
    } exewb_t;

endpackage
